//--- logic/rvCorePkg.sv
/*
 Shared widths, reset PC and APB master state codes
 Major opcode and ALU operation enums, instruction word views, control bundle
*/
package rvCorePkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int regCount = 1 << regAddrW;

    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // APB master FSM codes
    localparam logic [1:0] apbIdle   = 2'd0;
    localparam logic [1:0] apbSetup  = 2'd1;
    localparam logic [1:0] apbAccess = 2'd2;

    typedef enum logic [6:0] {
        opcOp    = 7'b0110011,
        opcOpImm = 7'b0010011,
        opcLoad  = 7'b0000011,
        opcStore = 7'b0100011,
        opcLui   = 7'b0110111,
        opcAuipc = 7'b0010111
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluPass  // LUI passes operand B straight through
    } aluOpE;

    // One instruction word, four ways to look at it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instU;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;  // Operand B from immediate
        logic  aluSrcPc;   // Operand A from PC
        aluOpE aluOp;
    } ctrlT;

endpackage

//--- logic/rvCoreIf.sv
/*
 Stage-to-stage bundles: ID/EX, EX/MEM and the writeback port
*/
`timescale 1ns/10ps

interface idExIf;
    import rvCorePkg::*;
    logic                valid;
    ctrlT                ctrl;
    logic [regAddrW-1:0] rs1, rs2, rd;
    logic [xlen-1:0]     rData1, rData2;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     pc;
    modport src (output valid, ctrl, rs1, rs2, rd, rData1, rData2, imm, pc);
    modport dst (input valid, ctrl, rs1, rs2, rd, rData1, rData2, imm, pc);
endinterface

interface exMemIf;
    import rvCorePkg::*;
    logic                valid;
    ctrlT                ctrl;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     aluResult;  // Also the data address
    logic [xlen-1:0]     storeData;
    modport src (output valid, ctrl, rd, aluResult, storeData);
    modport dst (input valid, ctrl, rd, aluResult, storeData);
endinterface

interface wbIf;
    import rvCorePkg::*;
    logic                regWrite;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     data;
    modport src (output regWrite, rd, data);
    modport dst (input regWrite, rd, data);
endinterface

//--- logic/coreFetch.sv
/*
 Fetch stage: PC register, instruction port and IF/ID register
*/
`timescale 1ns/10ps

module coreFetch (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       hold,
    output logic [rvCorePkg::xlen-1:0] instAddr,
    input  logic [rvCorePkg::xlen-1:0] instData,
    output rvCorePkg::instU            ifIdInst,
    output logic [rvCorePkg::xlen-1:0] ifIdPc,
    output logic                       ifIdValid
);
    import rvCorePkg::*;

    logic [xlen-1:0] pc;

    assign instAddr = pc;  // Memory answers in the same cycle

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= resetPc;
            ifIdValid <= 1'b0;
        end else if (!hold) begin
            pc        <= pc + 32'd4;
            ifIdValid <= 1'b1;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!hold) begin
            ifIdInst <= instU'(instData);
            ifIdPc   <= pc;
        end
    end

endmodule

//--- logic/coreDecode.sv
/*
 Decode stage: field decode, control and immediate generation
 Write-first register file, load-use detection and the ID/EX register
*/
`timescale 1ns/10ps

module coreDecode (
    input  logic                       clk,
    input  logic                       arstN,
    input  rvCorePkg::instU            ifIdInst,
    input  logic [rvCorePkg::xlen-1:0] ifIdPc,
    input  logic                       ifIdValid,
    input  logic                       memBusy,
    output logic                       loadUseStall,
    idExIf.src                         idEx,
    wbIf.dst                           wb
);
    import rvCorePkg::*;

    ctrlT                ctrl;
    logic                known;
    logic                usesRs1, usesRs2;
    logic [xlen-1:0]     imm;
    logic [regAddrW-1:0] rs1, rs2, rd;
    logic [xlen-1:0]     rData1, rData2;
    logic [xlen-1:0]     regs [regCount];

    // funct3 plus the bit-30 variant select
    function automatic aluOpE aluSel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        ctrl.regWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.aluSrcPc  = 1'b0;
        ctrl.aluOp     = aluAdd;
        imm            = {{20{ifIdInst.i.imm12[11]}}, ifIdInst.i.imm12};
        known          = 1'b1;
        usesRs1        = 1'b1;
        usesRs2        = 1'b0;
        case (opcodeE'(ifIdInst.r.opcode))
            opcOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluSel(ifIdInst.r.funct3, ifIdInst.r.funct7[5]);
                usesRs2       = 1'b1;
            end
            opcOpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // ADDI has no subtract so only SRAI looks at bit 30
                ctrl.aluOp     = aluSel(ifIdInst.r.funct3,
                    ifIdInst.r.funct3 == 3'b101 && ifIdInst.r.funct7[5]);
            end
            opcLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opcStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = {{20{ifIdInst.s.immHi[6]}}, ifIdInst.s.immHi,
                                  ifIdInst.s.immLo};
                usesRs2        = 1'b1;
            end
            opcLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPass;
                imm            = {ifIdInst.u.imm20, 12'b0};
                usesRs1        = 1'b0;
            end
            opcAuipc: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSrcPc  = 1'b1;
                imm            = {ifIdInst.u.imm20, 12'b0};
                usesRs1        = 1'b0;
            end
            default: begin
                known   = 1'b0;  // Becomes a bubble
                usesRs1 = 1'b0;
            end
        endcase
    end

    assign rs1 = ifIdInst.r.rs1;
    assign rs2 = ifIdInst.r.rs2;
    assign rd  = ctrl.regWrite ? ifIdInst.r.rd : '0;  // Stores report rd 0

    always_ff @(posedge clk) begin
        if (wb.regWrite && wb.rd != '0) regs[wb.rd] <= wb.data;
    end

    // Write-first reads with x0 tied to zero
    assign rData1 = (rs1 == '0) ? '0 :
                    (wb.regWrite && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 :
                    (wb.regWrite && wb.rd == rs2) ? wb.data : regs[rs2];

    assign loadUseStall = ifIdValid && known && idEx.valid && idEx.ctrl.memRead &&
                          idEx.rd != '0 &&
                          ((usesRs1 && idEx.rd == rs1) || (usesRs2 && idEx.rd == rs2));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) idEx.valid <= 1'b0;
        else if (!memBusy) idEx.valid <= ifIdValid && known && !loadUseStall;
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            idEx.ctrl   <= ctrl;
            idEx.rs1    <= rs1;
            idEx.rs2    <= rs2;
            idEx.rd     <= rd;
            idEx.rData1 <= rData1;
            idEx.rData2 <= rData2;
            idEx.imm    <= imm;
            idEx.pc     <= ifIdPc;
        end
    end

endmodule

//--- logic/coreExecute.sv
/*
 Execute stage: MEM and WB forwarding, operand select, ALU, EX/MEM register
*/
`timescale 1ns/10ps

module coreExecute (
    input logic clk,
    input logic arstN,
    input logic memBusy,
    idExIf.dst  idEx,
    exMemIf.src exMem,
    wbIf.dst    wb
);
    import rvCorePkg::*;

    logic [xlen-1:0] fwdA, fwdB;
    logic [xlen-1:0] opA, opB;
    logic [xlen-1:0] aluResult;
    logic            memHit1, memHit2;
    logic            wbHit1, wbHit2;

    // Load-use stall covers a load sitting in EX/MEM
    assign memHit1 = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead &&
                     exMem.rd != '0 && exMem.rd == idEx.rs1;
    assign memHit2 = exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead &&
                     exMem.rd != '0 && exMem.rd == idEx.rs2;
    assign wbHit1  = wb.regWrite && wb.rd != '0 && wb.rd == idEx.rs1;
    assign wbHit2  = wb.regWrite && wb.rd != '0 && wb.rd == idEx.rs2;

    // Newest producer wins
    assign fwdA = memHit1 ? exMem.aluResult : wbHit1 ? wb.data : idEx.rData1;
    assign fwdB = memHit2 ? exMem.aluResult : wbHit2 ? wb.data : idEx.rData2;

    assign opA = idEx.ctrl.aluSrcPc  ? idEx.pc  : fwdA;
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : fwdB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opA << opB[4:0];
            aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            aluSltu: aluResult = {31'b0, opA < opB};
            aluXor:  aluResult = opA ^ opB;
            aluSrl:  aluResult = opA >> opB[4:0];
            aluSra:  aluResult = $unsigned($signed(opA) >>> opB[4:0]);
            aluOr:   aluResult = opA | opB;
            aluAnd:  aluResult = opA & opB;
            default: aluResult = opB;  // Pass-through for LUI
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) exMem.valid <= 1'b0;
        else if (!memBusy) exMem.valid <= idEx.valid;
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.rd        <= idEx.rd;
            exMem.aluResult <= aluResult;
            exMem.storeData <= fwdB;  // Forwarded rs2
        end
    end

endmodule

//--- logic/coreResult.sv
/*
 Memory and writeback: APB master for LW/SW, MEM/WB register
 Writeback port and retire trace
*/
`timescale 1ns/10ps

module coreResult (
    input  logic                           clk,
    input  logic                           arstN,
    exMemIf.dst                            exMem,
    output logic                           memBusy,
    wbIf.src                               wb,
    output logic [rvCorePkg::xlen-1:0]     pAddr,
    output logic                           pSel,
    output logic                           pEnable,
    output logic                           pWrite,
    output logic [rvCorePkg::xlen-1:0]     pWData,
    input  logic [rvCorePkg::xlen-1:0]     pRData,
    input  logic                           pReady,
    output logic                           retireValid,
    output logic [rvCorePkg::regAddrW-1:0] retireRd,
    output logic [rvCorePkg::xlen-1:0]     retireData
);
    import rvCorePkg::*;

    logic [1:0]          apbState, apbNext;
    logic                memOp;
    logic                apbDone;
    logic                memWbRegWrite;
    logic [regAddrW-1:0] memWbRd;
    logic [xlen-1:0]     memWbData;

    assign memOp   = exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite);
    assign apbDone = (apbState == apbAccess) && pReady;
    assign memBusy = memOp && !apbDone;  // Freezes PC and all stages upstream

    always_comb begin
        case (apbState)
            apbIdle:   apbNext = memOp ? apbSetup : apbIdle;
            apbSetup:  apbNext = apbAccess;
            apbAccess: apbNext = pReady ? apbIdle : apbAccess;
            default:   apbNext = apbIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) apbState <= apbIdle;
        else apbState <= apbNext;
    end

    // EX/MEM is frozen during the transfer so address and data hold still
    assign pSel    = (apbState == apbSetup) || (apbState == apbAccess);
    assign pEnable = apbState == apbAccess;
    assign pWrite  = exMem.ctrl.memWrite;
    assign pAddr   = exMem.aluResult;
    assign pWData  = exMem.storeData;

    // MEM/WB control; retire pulses once even if MEM/WB is held
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWbRegWrite <= 1'b0;
            retireValid   <= 1'b0;
        end else if (memBusy) begin
            retireValid   <= 1'b0;
        end else begin
            memWbRegWrite <= exMem.valid && exMem.ctrl.regWrite;
            retireValid   <= exMem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            memWbRd   <= exMem.rd;
            memWbData <= exMem.ctrl.memRead ? pRData : exMem.aluResult;  // Stores keep address
        end
    end

    assign wb.regWrite = memWbRegWrite;
    assign wb.rd       = memWbRd;
    assign wb.data     = memWbData;

    assign retireRd   = memWbRd;
    assign retireData = memWbData;

endmodule

//--- logic/rvCore.sv
/*
 RV32I five-stage core top level
 Stage instances, stage bundles and the PC hold wire
*/
`timescale 1ns/10ps

module rvCore (
    input  logic                           clk,
    input  logic                           arstN,
    output logic [rvCorePkg::xlen-1:0]     instAddr,
    input  logic [rvCorePkg::xlen-1:0]     instData,
    output logic [rvCorePkg::xlen-1:0]     pAddr,
    output logic                           pSel,
    output logic                           pEnable,
    output logic                           pWrite,
    output logic [rvCorePkg::xlen-1:0]     pWData,
    input  logic [rvCorePkg::xlen-1:0]     pRData,
    input  logic                           pReady,
    output logic                           retireValid,
    output logic [rvCorePkg::regAddrW-1:0] retireRd,
    output logic [rvCorePkg::xlen-1:0]     retireData
);
    import rvCorePkg::*;

    instU            ifIdInst;
    logic [xlen-1:0] ifIdPc;
    logic            ifIdValid;
    logic            memBusy;
    logic            loadUseStall;
    logic            hold;

    idExIf  idExBus ();
    exMemIf exMemBus ();
    wbIf    wbBus ();

    assign hold = memBusy | loadUseStall;  // PC and IF/ID

    coreFetch fetchStage (
        .clk       (clk),
        .arstN     (arstN),
        .hold      (hold),
        .instAddr  (instAddr),
        .instData  (instData),
        .ifIdInst  (ifIdInst),
        .ifIdPc    (ifIdPc),
        .ifIdValid (ifIdValid)
    );

    coreDecode decodeStage (
        .clk          (clk),
        .arstN        (arstN),
        .ifIdInst     (ifIdInst),
        .ifIdPc       (ifIdPc),
        .ifIdValid    (ifIdValid),
        .memBusy      (memBusy),
        .loadUseStall (loadUseStall),
        .idEx         (idExBus.src),
        .wb           (wbBus.dst)
    );

    coreExecute executeStage (
        .clk     (clk),
        .arstN   (arstN),
        .memBusy (memBusy),
        .idEx    (idExBus.dst),
        .exMem   (exMemBus.src),
        .wb      (wbBus.dst)
    );

    coreResult resultStage (
        .clk         (clk),
        .arstN       (arstN),
        .exMem       (exMemBus.dst),
        .memBusy     (memBusy),
        .wb          (wbBus.src),
        .pAddr       (pAddr),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pWData      (pWData),
        .pRData      (pRData),
        .pReady      (pReady),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

endmodule

//--- dv/rvCore_properties.sv
/*
 Concurrent checks on the APB master and retire port, bound into rvCore
*/
`timescale 1ns/10ps

module rvCoreProperties (
    input logic                       clk,
    input logic                       arstN,
    input logic                       pSel,
    input logic                       pEnable,
    input logic                       pWrite,
    input logic                       pReady,
    input logic [rvCorePkg::xlen-1:0] pAddr,
    input logic [rvCorePkg::xlen-1:0] pWData,
    input logic                       retireValid
);

    // Access phase only follows a lone setup cycle
    enableAfterSetup: assert property (@(posedge clk) disable iff (!arstN)
        $rose(pEnable) |-> pSel && $past(pSel && !pEnable))
        else $error("pEnable rose without a preceding APB setup cycle");

    // Wait states keep the transfer frozen
    transferStable: assert property (@(posedge clk) disable iff (!arstN)
        $past(pEnable && !pReady) |->
            pEnable && $stable(pAddr) && $stable(pWData) && $stable(pWrite))
        else $error("APB transfer changed during a wait state");

    quietInReset: assert property (@(posedge clk)
        !arstN && $past(!arstN) |-> !retireValid && !pSel && !pEnable)
        else $error("retireValid, pSel or pEnable high during reset");

endmodule

bind rvCore rvCoreProperties apbRetireChecks (
    .clk         (clk),
    .arstN       (arstN),
    .pSel        (pSel),
    .pEnable     (pEnable),
    .pWrite      (pWrite),
    .pReady      (pReady),
    .pAddr       (pAddr),
    .pWData      (pWData),
    .retireValid (retireValid)
);

//--- dv/rvCoreTbClk.sv
/*
 Testbench clock (4 ns period) and active-low reset for 16 cycles
*/
`timescale 1ns/10ps

module rvCoreTbClk (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 arstN = 1'b1;  // Released off the edge like other inputs
    end

endmodule

//--- dv/rvCoreTb.sv
/*
 rvCore testbench: program table with expected retires, instruction memory,
 APB data memory with random wait states, retire and memory checks, timeout
*/
`timescale 1ns/10ps

module rvCoreTb;
    import rvCorePkg::*;

    typedef struct packed {
        logic [xlen-1:0]     inst;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     data;
    } stepT;

    localparam int numSteps      = 32;
    localparam int firstMemStep  = 22;  // The first SW
    localparam int numMemChecks  = 4;
    localparam int timeoutCycles = numSteps * 12 + 100;

    // Instruction word, expected retireRd, expected retireData
    localparam stepT steps [numSteps] = '{
        {32'h00500093, 5'd1,  32'h00000005},  // 00 addi x1, x0, 5
        {32'hFFD00113, 5'd2,  32'hFFFFFFFD},  // 04 addi x2, x0, -3
        {32'h002081B3, 5'd3,  32'h00000002},  // 08 add  x3, x1, x2
        {32'h40208233, 5'd4,  32'h00000008},  // 0c sub  x4, x1, x2
        {32'h001122B3, 5'd5,  32'h00000001},  // 10 slt  x5, x2, x1
        {32'h00113333, 5'd6,  32'h00000000},  // 14 sltu x6, x2, x1
        {32'h0F014393, 5'd7,  32'hFFFFFF0D},  // 18 xori x7, x2, 0xf0
        {32'h00409413, 5'd8,  32'h00000050},  // 1c slli x8, x1, 4
        {32'h01C15493, 5'd9,  32'h0000000F},  // 20 srli x9, x2, 28
        {32'h40115513, 5'd10, 32'hFFFFFFFE},  // 24 srai x10, x2, 1
        {32'h009465B3, 5'd11, 32'h0000005F},  // 28 or   x11, x8, x9
        {32'h0075F633, 5'd12, 32'h0000000D},  // 2c and  x12, x11, x7
        {32'h004096B3, 5'd13, 32'h00000500},  // 30 sll  x13, x1, x4
        {32'h40115733, 5'd14, 32'hFFFFFFFF},  // 34 sra  x14, x2, x1
        {32'h001157B3, 5'd15, 32'h07FFFFFF},  // 38 srl  x15, x2, x1
        {32'h0020C833, 5'd16, 32'hFFFFFFF8},  // 3c xor  x16, x1, x2
        {32'h123458B7, 5'd17, 32'h12345000},  // 40 lui  x17, 0x12345
        {32'h00001917, 5'd18, 32'h00001044},  // 44 auipc x18, 1
        {32'h00708013, 5'd0,  32'h0000000C},  // 48 addi x0, x1, 7
        {32'h001009B3, 5'd19, 32'h00000005},  // 4c add  x19, x0, x1
        {32'h80000A13, 5'd20, 32'hFFFFF800},  // 50 addi x20, x0, -2048
        {32'h04000A93, 5'd21, 32'h00000040},  // 54 addi x21, x0, 0x40
        {32'h011AA423, 5'd0,  32'h00000048},  // 58 sw   x17, 8(x21)
        {32'h008AAB03, 5'd22, 32'h12345000},  // 5c lw   x22, 8(x21)
        {32'h001B0BB3, 5'd23, 32'h12345005},  // 60 add  x23, x22, x1
        {32'hFF4AAE23, 5'd0,  32'h0000003C},  // 64 sw   x20, -4(x21)
        {32'h01002C03, 5'd24, 32'hFFEF0010},  // 68 lw   x24, 0x10(x0)
        {32'h001C0C93, 5'd25, 32'hFFEF0011},  // 6c addi x25, x24, 1
        {32'hFFCAAD03, 5'd26, 32'hFFFFF800},  // 70 lw   x26, -4(x21)
        {32'h01A02023, 5'd0,  32'h00000000},  // 74 sw   x26, 0(x0)
        {32'h00002D83, 5'd27, 32'hFFFFF800},  // 78 lw   x27, 0(x0)
        {32'h41AD8E33, 5'd28, 32'h00000000}   // 7c sub  x28, x27, x26
    };

    // Byte address, final word
    localparam logic [63:0] memChecks [numMemChecks] = '{
        {32'h00000048, 32'h12345000},
        {32'h0000003C, 32'hFFFFF800},
        {32'h00000000, 32'hFFFFF800},
        {32'h00000010, 32'hFFEF0010}  // Never written
    };

    logic                clk, arstN;
    logic [xlen-1:0]     instAddr, instData;
    logic [xlen-1:0]     pAddr, pWData, pRData;
    logic                pSel, pEnable, pWrite, pReady;
    logic                retireValid;
    logic [regAddrW-1:0] retireRd;
    logic [xlen-1:0]     retireData;
    logic [xlen-1:0]     imem [64];
    logic [xlen-1:0]     dmem [64];
    logic                readyNext;
    logic [xlen-1:0]     dataNext;
    int                  errors = 0;
    int                  checks = 0;
    int                  retireCount = 0;
    int                  cycleCount = 0;
    int                  waitLeft = 0;
    int unsigned         seedInit;

    rvCoreTbClk clkGen (
        .clk   (clk),
        .arstN (arstN)
    );

    rvCore i_rvCore (
        .clk         (clk),
        .arstN       (arstN),
        .instAddr    (instAddr),
        .instData    (instData),
        .pAddr       (pAddr),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pWData      (pWData),
        .pRData      (pRData),
        .pReady      (pReady),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    // Unique start value for every byte address
    function automatic logic [xlen-1:0] fillWord(input logic [xlen-1:0] addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    task automatic checkValue(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    task automatic waitRetire;
        do @(negedge clk); while (!retireValid);
    endtask

    initial begin
        for (int i = 0; i < 64; i++) begin
            if (i < numSteps) imem[i] = steps[i].inst;
            else imem[i] = '0;  // Unknown opcode never retires
        end
    end

    assign instData = (instAddr < 32'd256) ? imem[instAddr[7:2]] : '0;

    // APB slave decides at the falling edge and drives 1 ns after the rising edge
    initial begin
        pReady   = 1'b0;
        pRData   = '0;
        seedInit = $urandom(40411);
        for (int i = 0; i < 64; i++) dmem[i] = fillWord(xlen'(i * 4));
        forever begin
            @(negedge clk);
            readyNext = 1'b0;
            if (pSel && !pEnable) begin
                waitLeft  = $urandom % 4;  // 0 to 3 wait states
                readyNext = (waitLeft == 0);
            end else if (pSel && pEnable && !pReady) begin
                waitLeft  = waitLeft - 1;
                readyNext = (waitLeft == 0);
            end else if (pSel && pEnable && pWrite) begin
                dmem[pAddr[7:2]] = pWData;  // Completes at the next edge
            end
            dataNext = dmem[pAddr[7:2]];
            @(posedge clk);
            #1;
            pReady = readyNext;
            pRData = dataNext;
        end
    end

    // Retire count and early APB activity
    always @(negedge clk) begin
        if (arstN && pSel && retireCount < firstMemStep) begin
            errors++;
            $display("APB transfer started before the first load or store reached memory");
        end
        if (retireValid) begin
            retireCount++;
            if (retireCount > numSteps) begin
                errors++;
                $display("An instruction retired past the end of the program");
            end
        end
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        errors++;
        $display("Timeout: the program did not finish within %0d cycles", timeoutCycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        @(posedge arstN);
        for (int i = 0; i < numSteps; i++) begin
            waitRetire();
            checkValue($sformatf("retireRd[%0d]", i), xlen'(retireRd), xlen'(steps[i].rd));
            checkValue($sformatf("retireData[%0d]", i), retireData, steps[i].data);
        end
        repeat (20) @(negedge clk);  // Let stray retires show up
        for (int j = 0; j < numMemChecks; j++) begin
            checkValue($sformatf("dmem[0x%02h]", memChecks[j][63:32]),
                       dmem[memChecks[j][39:34]], memChecks[j][31:0]);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("Finished with no errors");
        else $display("Finished with errors");
        $finish;
    end

endmodule

//--- rvCore.f
logic/rvCorePkg.sv
logic/rvCoreIf.sv
logic/coreFetch.sv
logic/coreDecode.sv
logic/coreExecute.sv
logic/coreResult.sv
logic/rvCore.sv
dv/rvCore_properties.sv
dv/rvCoreTbClk.sv
dv/rvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the rvCore testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module rvCoreTb -o rvCoreSim -f rvCore.f \
    && ./obj_dir/rvCoreSim > sim.log 2>&1
simStatus=$?
[ -f sim.log ] && cat sim.log
[ "$simStatus" -eq 0 ] && [ -f sim.log ] && ! grep -q "Finished with errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
